// ==== source/balancePkg.sv ====
`default_nettype none

package balancePkg;

    // Angles, gyro increments and motor power are all signed Q8.8
    localparam int ANGLE_W   = 16;
    localparam int FRAC_BITS = 8;

    // Filter weight of 1.0 in the same fraction format
    localparam int ALPHA_ONE = 256;

    // PID integral accumulator and gain format
    localparam int SUM_W      = 24;
    localparam int GAIN_W     = 8;
    localparam int GAIN_SHIFT = 4;

    // PWM resolution, one period is 2**DUTY_W cycles
    localparam int DUTY_W = 8;

    // Saturation limits
    localparam logic signed [ANGLE_W-1:0] ANGLE_MAX = 16'sh7fff;
    localparam logic signed [ANGLE_W-1:0] ANGLE_MIN = 16'sh8000;
    localparam logic signed [SUM_W-1:0]   SUM_MAX   = 24'sh7fffff;
    localparam logic signed [SUM_W-1:0]   SUM_MIN   = 24'sh800000;

endpackage

`default_nettype wire

// ==== source/sampleTimer.sv ====
`timescale 1ns/100ps
`default_nettype none

module sampleTimer #(
    parameter int SAMPLE_DIV = 512
) (
    input  logic clk,
    input  logic rstN,
    input  logic enable,
    output logic sampleStb
);

    localparam int CNT_W = $clog2(SAMPLE_DIV);
    localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(SAMPLE_DIV - 1);

    logic [CNT_W-1:0] count;

    // Counter sits at zero while disabled, so the first strobe
    // comes a full sample period after enable rises
    always_ff @(posedge clk) begin
        if (!rstN || !enable) begin
            count     <= '0;
            sampleStb <= 1'b0;
        end else begin
            sampleStb <= (count == LAST_COUNT);
            if (count == LAST_COUNT) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/complementaryFilter.sv ====
`timescale 1ns/100ps
`default_nettype none

module complementaryFilter #(
    parameter int ALPHA = 230
) (
    input  logic                                      clk,
    input  logic                                      rstN,
    input  logic                                      sampleStb,
    input  logic signed [balancePkg::ANGLE_W-1:0]     gyroRate,
    input  logic signed [balancePkg::ANGLE_W-1:0]     acceAngle,
    output logic signed [balancePkg::ANGLE_W-1:0]     angle,
    output logic                                      angleValid
);

    import balancePkg::*;

    // Room for a 9-bit weight times a 17-bit angle, twice over
    localparam int BLEND_W = 2 * ANGLE_W;

    localparam logic signed [BLEND_W-1:0] GYRO_WEIGHT = BLEND_W'(ALPHA);
    localparam logic signed [BLEND_W-1:0] ACCE_WEIGHT = BLEND_W'(ALPHA_ONE - ALPHA);

    logic signed [BLEND_W-1:0] gyroProp;
    logic signed [BLEND_W-1:0] blend;
    logic signed [BLEND_W-1:0] shifted;
    logic signed [ANGLE_W-1:0] angleNext;

    // Gyro path integrates the increment onto the last filtered angle
    assign gyroProp = angle + gyroRate;
    assign blend    = GYRO_WEIGHT * gyroProp + ACCE_WEIGHT * acceAngle;
    assign shifted  = blend >>> FRAC_BITS;

    always_comb begin
        if (shifted > ANGLE_MAX) begin
            angleNext = ANGLE_MAX;
        end else if (shifted < ANGLE_MIN) begin
            angleNext = ANGLE_MIN;
        end else begin
            angleNext = shifted[ANGLE_W-1:0];
        end
    end

    // Angle is kept between samples, also while the robot is disabled
    always_ff @(posedge clk) begin
        if (!rstN) begin
            angle      <= '0;
            angleValid <= 1'b0;
        end else begin
            angleValid <= sampleStb;
            if (sampleStb) begin
                angle <= angleNext;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/pidController.sv ====
`timescale 1ns/100ps
`default_nettype none

module pidController #(
    parameter logic signed [balancePkg::ANGLE_W-1:0] TARGET_ANGLE = '0,
    parameter logic [balancePkg::GAIN_W-1:0]         KP           = 8'd16,
    parameter logic [balancePkg::GAIN_W-1:0]         KI           = 8'd1,
    parameter logic [balancePkg::GAIN_W-1:0]         KD           = 8'd8
) (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic                                  enable,
    input  logic signed [balancePkg::ANGLE_W-1:0] angle,
    input  logic                                  angleValid,
    output logic signed [balancePkg::ANGLE_W-1:0] motorPower,
    output logic                                  powerValid
);

    import balancePkg::*;

    // Wide enough for the three products plus carries
    localparam int ACC_W = SUM_W + GAIN_W + 2;

    // Gains are unsigned, one extra bit keeps them positive in signed math
    localparam logic signed [GAIN_W:0] KP_S = {1'b0, KP};
    localparam logic signed [GAIN_W:0] KI_S = {1'b0, KI};
    localparam logic signed [GAIN_W:0] KD_S = {1'b0, KD};

    logic signed [SUM_W-1:0]   integral;
    logic signed [ANGLE_W-1:0] prevAngle;

    logic signed [ANGLE_W:0]   errDiff;
    logic signed [ANGLE_W-1:0] error;
    logic signed [SUM_W:0]     integralSum;
    logic signed [SUM_W-1:0]   integralNext;
    logic signed [ANGLE_W:0]   deriv;
    logic signed [ACC_W-1:0]   pidSum;
    logic signed [ACC_W-1:0]   pidShifted;
    logic signed [ANGLE_W-1:0] powerNext;

    // Proportional term input
    assign errDiff = angle - TARGET_ANGLE;

    always_comb begin
        if (errDiff > ANGLE_MAX) begin
            error = ANGLE_MAX;
        end else if (errDiff < ANGLE_MIN) begin
            error = ANGLE_MIN;
        end else begin
            error = errDiff[ANGLE_W-1:0];
        end
    end

    // Integral includes the current error, clipped to the accumulator range
    assign integralSum = integral + error;

    always_comb begin
        if (integralSum > SUM_MAX) begin
            integralNext = SUM_MAX;
        end else if (integralSum < SUM_MIN) begin
            integralNext = SUM_MIN;
        end else begin
            integralNext = integralSum[SUM_W-1:0];
        end
    end

    // Derivative on the measurement avoids a kick when the target changes
    assign deriv = angle - prevAngle;

    assign pidSum     = KP_S * error + KI_S * integralNext + KD_S * deriv;
    assign pidShifted = pidSum >>> GAIN_SHIFT;

    always_comb begin
        if (pidShifted > ANGLE_MAX) begin
            powerNext = ANGLE_MAX;
        end else if (pidShifted < ANGLE_MIN) begin
            powerNext = ANGLE_MIN;
        end else begin
            powerNext = pidShifted[ANGLE_W-1:0];
        end
    end

    // Dropping enable wipes the history so re-enabling starts clean
    always_ff @(posedge clk) begin
        if (!rstN || !enable) begin
            integral   <= '0;
            prevAngle  <= '0;
            motorPower <= '0;
            powerValid <= 1'b0;
        end else begin
            powerValid <= angleValid;
            if (angleValid) begin
                integral   <= integralNext;
                prevAngle  <= angle;
                motorPower <= powerNext;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/motorPwm.sv ====
`timescale 1ns/100ps
`default_nettype none

module motorPwm (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic                                  enable,
    input  logic signed [balancePkg::ANGLE_W-1:0] motorPower,
    input  logic                                  powerValid,
    output logic                                  pwm,
    output logic                                  dirForward
);

    import balancePkg::*;

    localparam logic [DUTY_W-1:0] DUTY_FULL = '1;

    logic [DUTY_W-1:0]  count;
    logic [DUTY_W-1:0]  duty;
    logic [DUTY_W-1:0]  pendDuty;
    logic               pendDir;
    logic [ANGLE_W:0]   magnitude;
    logic [DUTY_W-1:0]  dutyClamped;

    // Extra bit so that -32768 has a representable magnitude
    assign magnitude = motorPower[ANGLE_W-1] ? (ANGLE_W + 1)'(-motorPower)
                                             : (ANGLE_W + 1)'(motorPower);

    assign dutyClamped = (magnitude > (ANGLE_W + 1)'(DUTY_FULL)) ? DUTY_FULL
                                                                : magnitude[DUTY_W-1:0];

    // Counter free-runs, one PWM period per wrap
    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // New power waits in the pending register until the period ends
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pendDuty   <= '0;
            pendDir    <= 1'b1;
            duty       <= '0;
            dirForward <= 1'b1;
        end else if (!enable) begin
            pendDuty <= '0;
            duty     <= '0;
        end else begin
            if (powerValid) begin
                pendDuty <= dutyClamped;
                pendDir  <= ~motorPower[ANGLE_W-1];
            end
            if (count == DUTY_FULL) begin
                duty       <= pendDuty;
                dirForward <= pendDir;
            end
        end
    end

    // Kill switch cuts the drive without waiting for the period
    assign pwm = enable && (count < duty);

endmodule

`default_nettype wire

// ==== source/balanceTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module balanceTop #(
    parameter int                                    SAMPLE_DIV   = 512,
    parameter int                                    ALPHA        = 230,
    parameter logic signed [balancePkg::ANGLE_W-1:0] TARGET_ANGLE = '0,
    parameter logic [balancePkg::GAIN_W-1:0]         KP           = 8'd16,
    parameter logic [balancePkg::GAIN_W-1:0]         KI           = 8'd1,
    parameter logic [balancePkg::GAIN_W-1:0]         KD           = 8'd8
) (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic                                  enable,
    input  logic signed [balancePkg::ANGLE_W-1:0] gyroRate,
    input  logic signed [balancePkg::ANGLE_W-1:0] acceAngle,
    output logic signed [balancePkg::ANGLE_W-1:0] angle,
    output logic                                  angleValid,
    output logic signed [balancePkg::ANGLE_W-1:0] motorPower,
    output logic                                  powerValid,
    output logic                                  pwm,
    output logic                                  dirForward
);

    logic sampleStb;

    sampleTimer #(
        .SAMPLE_DIV(SAMPLE_DIV)
    ) sampleTimer_i (
        .clk      (clk),
        .rstN     (rstN),
        .enable   (enable),
        .sampleStb(sampleStb)
    );

    // Sensors are read on the strobe, angle follows one cycle later
    complementaryFilter #(
        .ALPHA(ALPHA)
    ) complementaryFilter_i (
        .clk       (clk),
        .rstN      (rstN),
        .sampleStb (sampleStb),
        .gyroRate  (gyroRate),
        .acceAngle (acceAngle),
        .angle     (angle),
        .angleValid(angleValid)
    );

    pidController #(
        .TARGET_ANGLE(TARGET_ANGLE),
        .KP          (KP),
        .KI          (KI),
        .KD          (KD)
    ) pidController_i (
        .clk       (clk),
        .rstN      (rstN),
        .enable    (enable),
        .angle     (angle),
        .angleValid(angleValid),
        .motorPower(motorPower),
        .powerValid(powerValid)
    );

    // Power reaches the drive at the next PWM period boundary
    motorPwm motorPwm_i (
        .clk       (clk),
        .rstN      (rstN),
        .enable    (enable),
        .motorPower(motorPower),
        .powerValid(powerValid),
        .pwm       (pwm),
        .dirForward(dirForward)
    );

endmodule

`default_nettype wire

// ==== tb/balanceTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module balanceTb;

    import balancePkg::*;

    localparam int SAMPLE_DIV   = 512;
    localparam int ALPHA        = 230;
    localparam int TARGET_ANGLE = 0;
    localparam int KP_GAIN      = 16;
    localparam int KI_GAIN      = 1;
    localparam int KD_GAIN      = 8;
    localparam int NUM_SAMPLES  = 40;
    localparam int KILL_SAMPLE  = 30;
    localparam int CYCLE_LIMIT  = (NUM_SAMPLES + 8) * SAMPLE_DIV + 64;

    // Test numbers for the error counters
    localparam int T_RESET = 0;
    localparam int T_CADENCE = 1;
    localparam int T_FILTER = 2;
    localparam int T_PID = 3;
    localparam int T_PWM = 4;
    localparam int T_KILL = 5;

    logic clk = 1'b0;
    logic rstN;
    logic enable;
    logic signed [ANGLE_W-1:0] gyroRate;
    logic signed [ANGLE_W-1:0] acceAngle;
    logic signed [ANGLE_W-1:0] angle;
    logic angleValid;
    logic signed [ANGLE_W-1:0] motorPower;
    logic powerValid;
    logic pwm;
    logic dirForward;

    // Reference model state
    logic signed [ANGLE_W-1:0] modelAngle;
    logic signed [SUM_W-1:0] modelInteg;
    logic signed [ANGLE_W-1:0] modelPrev;
    logic signed [ANGLE_W-1:0] expAngle;
    logic signed [ANGLE_W-1:0] expPower;
    logic signed [ANGLE_W-1:0] expFresh;
    logic [DUTY_W-1:0] phase;
    logic [DUTY_W-1:0] pendDuty;
    logic [DUTY_W-1:0] curDuty;
    logic pendDir;
    logic curDir;
    logic periodOk;
    int highCnt;

    int sinceValid;
    logic seenValid;
    logic avDly;
    logic resetCheck;
    logic started;
    logic firstAfterKill;
    logic [15:0] lfsrState = 16'd56;
    int cycleCount = 0;
    int errCount[6];

    always #4 clk = ~clk;

    balanceTop #(
        .SAMPLE_DIV  (SAMPLE_DIV),
        .ALPHA       (ALPHA),
        .TARGET_ANGLE(ANGLE_W'(TARGET_ANGLE)),
        .KP          (GAIN_W'(KP_GAIN)),
        .KI          (GAIN_W'(KI_GAIN)),
        .KD          (GAIN_W'(KD_GAIN))
    ) balanceTop_i (
        .clk       (clk),
        .rstN      (rstN),
        .enable    (enable),
        .gyroRate  (gyroRate),
        .acceAngle (acceAngle),
        .angle     (angle),
        .angleValid(angleValid),
        .motorPower(motorPower),
        .powerValid(powerValid),
        .pwm       (pwm),
        .dirForward(dirForward)
    );

    function automatic logic signed [ANGLE_W-1:0] satAngle(input longint v);
        longint c;
        c = v;
        if (v > 32767) begin
            c = 32767;
        end else if (v < -32768) begin
            c = -32768;
        end
        return c[ANGLE_W-1:0];
    endfunction

    function automatic logic signed [SUM_W-1:0] satSum(input longint v);
        longint c;
        c = v;
        if (v > 8388607) begin
            c = 8388607;
        end else if (v < -8388608) begin
            c = -8388608;
        end
        return c[SUM_W-1:0];
    endfunction

    // Weighted blend of gyro path and accelerometer, Q8.8 weights
    function automatic logic signed [ANGLE_W-1:0] filterStep(input longint old, input longint g,
                                                             input longint a);
        longint b;
        b = ALPHA * (old + g) + (ALPHA_ONE - ALPHA) * a;
        return satAngle(b >>> FRAC_BITS);
    endfunction

    function automatic logic signed [SUM_W-1:0] nextInteg(input longint a, input longint integ);
        return satSum(integ + longint'(satAngle(a - TARGET_ANGLE)));
    endfunction

    function automatic logic signed [ANGLE_W-1:0] pidStep(input longint a, input longint integ,
                                                          input longint prev);
        longint err;
        longint sum;
        err = satAngle(a - TARGET_ANGLE);
        sum = KP_GAIN * err + KI_GAIN * longint'(nextInteg(a, integ)) + KD_GAIN * (a - prev);
        return satAngle(sum >>> GAIN_SHIFT);
    endfunction

    function automatic logic [DUTY_W-1:0] dutyOf(input longint p);
        longint mag;
        mag = (p < 0) ? -p : p;
        if (mag > 255) begin
            mag = 255;
        end
        return mag[DUTY_W-1:0];
    endfunction

    // Galois LFSR, taps 0xb400, one step per bit
    function automatic logic lfsrBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 16'hb400;
        end
        return outBit;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrBit()};
        end
        return v;
    endfunction

    assign expAngle = filterStep(modelAngle, gyroRate, acceAngle);
    assign expPower = pidStep(modelAngle, modelInteg, modelPrev);
    assign expFresh = pidStep(modelAngle, 0, 0);

    // Model reads pre-edge values, so it lines up with the DUT registers
    always @(posedge clk) begin
        if (!rstN) begin
            modelAngle <= '0;
            modelInteg <= '0;
            modelPrev  <= '0;
            phase      <= '0;
            pendDuty   <= '0;
            curDuty    <= '0;
            pendDir    <= 1'b1;
            curDir     <= 1'b1;
            periodOk   <= 1'b0;
            highCnt    <= 0;
        end else begin
            phase   <= phase + 1'b1;
            highCnt <= (phase == 8'hff) ? 0 : highCnt + (pwm ? 1 : 0);
            if (angleValid) begin
                modelAngle <= expAngle;
            end
            if (!enable) begin
                modelInteg <= '0;
                modelPrev  <= '0;
                pendDuty   <= '0;
                curDuty    <= '0;
                periodOk   <= 1'b0;
            end else begin
                if (powerValid) begin
                    modelInteg <= nextInteg(modelAngle, modelInteg);
                    modelPrev  <= modelAngle;
                    pendDuty   <= dutyOf(expPower);
                    pendDir    <= (expPower >= 0);
                end
                if (phase == 8'hff) begin
                    curDuty  <= pendDuty;
                    curDir   <= pendDir;
                    periodOk <= 1'b1;
                end
            end
        end
    end

    // Strobe spacing bookkeeping
    always @(posedge clk) begin
        avDly <= angleValid;
        if (!enable) begin
            seenValid  <= 1'b0;
            sinceValid <= 0;
        end else if (angleValid) begin
            seenValid  <= 1'b1;
            sinceValid <= 1;
        end else begin
            sinceValid <= sinceValid + 1;
        end
    end

    resetValues: assert property (@(negedge clk) resetCheck |-> angle == '0 && motorPower == '0)
        else begin
            $display("FAIL angle/motorPower in reset expected 0000/0000 got %h/%h",
                     angle, motorPower);
            errCount[T_RESET]++;
        end

    resetLevels: assert property (@(negedge clk) resetCheck |->
            {balanceTop_i.sampleStb, angleValid, powerValid, pwm, dirForward} == 5'b00001)
        else begin
            $display("FAIL {sampleStb,angleValid,powerValid,pwm,dirForward} expected 01 got %h",
                     {balanceTop_i.sampleStb, angleValid, powerValid, pwm, dirForward});
            errCount[T_RESET]++;
        end

    spacing: assert property (@(negedge clk) disable iff (!rstN)
            (enable && seenValid && angleValid) |-> sinceValid == SAMPLE_DIV)
        else begin
            $display("angleValid pulse came %0d cycles after the previous one", sinceValid);
            errCount[T_CADENCE]++;
        end

    missing: assert property (@(negedge clk) disable iff (!rstN)
            (enable && seenValid) |-> sinceValid <= SAMPLE_DIV)
        else begin
            $display("angleValid pulse missing, %0d cycles since the last one", sinceValid);
            errCount[T_CADENCE]++;
        end

    follow: assert property (@(negedge clk) disable iff (!rstN) enable |-> powerValid == avDly)
        else begin
            $display("powerValid did not follow angleValid by one cycle");
            errCount[T_CADENCE]++;
        end

    filterValue: assert property (@(negedge clk) disable iff (!rstN)
            angleValid |-> angle == expAngle)
        else begin
            $display("FAIL angle expected %h got %h", expAngle, angle);
            errCount[T_FILTER]++;
        end

    pidValue: assert property (@(negedge clk) disable iff (!rstN)
            powerValid |-> motorPower == expPower)
        else begin
            $display("FAIL motorPower expected %h got %h", expPower, motorPower);
            errCount[T_PID]++;
        end

    pwmDuty: assert property (@(negedge clk) disable iff (!rstN)
            (periodOk && enable && phase == 8'hff) |-> highCnt + (pwm ? 1 : 0) == int'(curDuty))
        else begin
            $display("FAIL pwm high cycles expected %h got %h", curDuty, highCnt + (pwm ? 1 : 0));
            errCount[T_PWM]++;
        end

    pwmDir: assert property (@(negedge clk) disable iff (!rstN) dirForward == curDir)
        else begin
            $display("FAIL dirForward expected %h got %h", curDir, dirForward);
            errCount[T_PWM]++;
        end

    killPwm: assert property (@(negedge clk) (started && !enable) |-> !pwm)
        else begin
            $display("pwm still high while enable is low");
            errCount[T_KILL]++;
        end

    killStb: assert property (@(negedge clk) (started && !enable) |->
            !balanceTop_i.sampleStb && !angleValid && !powerValid)
        else begin
            $display("strobe seen while enable is low");
            errCount[T_KILL]++;
        end

    // History must be gone on the first sample after re-enable
    freshPower: assert property (@(negedge clk) (firstAfterKill && powerValid) |->
            motorPower == expFresh)
        else begin
            $display("FAIL motorPower after re-enable expected %h got %h", expFresh, motorPower);
            errCount[T_KILL]++;
        end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    // Blocks of large inputs push angle and power into saturation
    task automatic driveSample(input int s);
        logic [7:0] g;
        logic [11:0] a;
        g = 8'(randBits(8));
        a = 12'(randBits(12));
        if (s >= 10 && s < 16) begin
            gyroRate  = 16'sh7000;
            acceAngle = 16'sh7fff;
        end else if (s >= 20 && s < 26) begin
            gyroRate  = 16'sh9000;
            acceAngle = 16'sh8000;
        end else begin
            gyroRate  = {{8{g[7]}}, g};
            acceAngle = {{4{a[11]}}, a};
        end
    endtask

    task automatic waitPowerValid();
        do begin
            @(posedge clk);
        end while (!powerValid);
    endtask

    // Drop enable halfway through a PWM period, then bring it back
    task automatic killAndRestore();
        repeat (50) @(posedge clk);
        while (phase != 8'd128) begin
            @(posedge clk);
        end
        #1 enable = 1'b0;
        repeat (300) @(posedge clk);
        #1 enable = 1'b1;
        firstAfterKill = 1'b1;
    endtask

    task automatic reportTest(input int idx, input string name);
        if (errCount[idx] == 0) begin
            $display("Test %0d %s: passed", idx + 1, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", idx + 1, name, errCount[idx]);
        end
    endtask

    initial begin
        int total;
        rstN = 1'b0;
        enable = 1'b0;
        gyroRate = '0;
        acceAngle = '0;
        resetCheck = 1'b0;
        started = 1'b0;
        firstAfterKill = 1'b0;
        for (int t = 0; t < 6; t++) begin
            errCount[t] = 0;
        end
        @(posedge clk);
        #1 resetCheck = 1'b1;
        repeat (15) @(posedge clk);
        #1 rstN = 1'b1;
        repeat (4) @(posedge clk);
        #1 resetCheck = 1'b0;
        reportTest(T_RESET, "reset state");
        driveSample(0);
        enable = 1'b1;
        started = 1'b1;
        for (int s = 0; s < NUM_SAMPLES; s++) begin
            waitPowerValid();
            #1 driveSample(s + 1);
            if (s == KILL_SAMPLE) begin
                killAndRestore();
            end
            if (s == KILL_SAMPLE + 1) begin
                firstAfterKill = 1'b0;
                reportTest(T_KILL, "enable kill switch");
            end
        end
        // Let the last duty run through a few full periods
        repeat (3 * 256) @(posedge clk);
        reportTest(T_CADENCE, "sample cadence");
        reportTest(T_FILTER, "filter value");
        reportTest(T_PID, "PID value");
        reportTest(T_PWM, "PWM output");
        total = 0;
        for (int t = 0; t < 6; t++) begin
            total += errCount[t];
        end
        $display("Tests run: 6, errors: %0d", total);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/balancePkg.sv
source/sampleTimer.sv
source/complementaryFilter.sv
source/pidController.sv
source/motorPwm.sv
source/balanceTop.sv
tb/balanceTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal -f vlog.f \
       --top-module balanceTb -o balanceSim > build.log 2>&1 \
  && ./obj_dir/balanceSim > sim.log 2>&1 \
  && grep -q "Done: no errors" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
